/* rvDecode_defines.svh */
`ifndef RVDECODE_DEFINES_SVH
`define RVDECODE_DEFINES_SVH

// instructions per fetch packet, also the lane count
`define RV_LANES 2

// data, pc and immediate width
`define RV_XLEN 32

// fetchValid to decodeValid, in cycles
// splitter + lane + collector, one stage each
`define RV_DEC_LATENCY 3

`endif

/* rvDecodePkg.sv */
`include "rvDecode_defines.svh"

package rvDecodePkg;

    // rv32i major opcodes handled here, everything else decodes illegal
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_AUIPC  = 7'b0010111,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // write-back source
    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_MEM  = 2'b01,
        RES_PC4  = 2'b10   // link address
    } resultSrc_e;

    // next pc source
    typedef enum logic [1:0] {
        PC_PLUS4      = 2'b00,
        PC_PLUS_IMM   = 2'b01, // branch / jal
        PC_ALU_RESULT = 2'b10  // jalr
    } pcSrc_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_U = 3'b011,
        IMM_J = 3'b100
    } immFmt_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui
    } aluOp_e;

    // encoded as funct3 of the load/store itself
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } memSize_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0]            pc;    // pc of lane 0
        logic [`RV_LANES-1:0][31:0]     instr;
    } fetchPacket_t;

    typedef struct packed {
        logic [31:0]         instr;
        logic [`RV_XLEN-1:0] pc;
    } laneIn_t;

    typedef struct packed {
        logic                valid;
        logic                illegal;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
        resultSrc_e          resultSrc;
        pcSrc_e              pcSrc;
        immFmt_e             immFmt;
        aluOp_e              aluOp;
        memSize_e            memSize;
        logic                aluSrc;    // operand b is the immediate
        logic                regWrite;
        logic                memWrite;
        logic                branch;
        logic                jump;
        logic                usesPc;    // operand a is the pc
    } laneCtrl_t;

    typedef struct packed {
        laneCtrl_t [`RV_LANES-1:0] lane;
        logic                      illegalAny;
        logic [`RV_LANES-1:0]      squashMask;
    } decodeBundle_t;

endpackage

/* laneSplitter.sv */
`timescale 1ns/1ps
`include "rvDecode_defines.svh"

module laneSplitter import rvDecodePkg::*; (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         fetchValid,  // one-cycle strobe
    input  fetchPacket_t                 fetchPacket,
    output logic                         laneValid,   // shared by every lane
    output laneIn_t [`RV_LANES-1:0]      laneIn
);

    fetchPacket_t pktQ;  // captured packet

    // strobe stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            laneValid <= 1'b0;
        end else begin
            laneValid <= fetchValid;
        end
    end

    // packet payload, held between strobes
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            pktQ <= fetchPacket;
        end
    end

    // one word per lane, pc steps by four per lane
    for (genvar i = 0; i < `RV_LANES; i++) begin : gSlice
        assign laneIn[i].instr = pktQ.instr[i];
        assign laneIn[i].pc    = pktQ.pc + `RV_XLEN'(4 * i);
    end

endmodule

/* decodeLane.sv */
`timescale 1ns/1ps
`include "rvDecode_defines.svh"

module decodeLane import rvDecodePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,   // lane strobe from splitter
    input  laneIn_t   laneIn,
    output logic      outValid,
    output laneCtrl_t laneCtrl
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] instr;
    laneCtrl_t  ctrlD;     // decoded, before the register

    // funct3 to alu op for OP / OP_IMM, altOp picks sub/sra
    function automatic aluOp_e aluFromFunct3(input logic [2:0] f3, input logic altOp);
        aluOp_e op;
        case (f3)
            3'b000:  op = altOp ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = altOp ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign instr  = laneIn.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        // safe defaults, nothing written
        ctrlD           = '0;
        ctrlD.valid     = inValid;
        ctrlD.pc        = laneIn.pc;
        ctrlD.rd        = instr[11:7];
        ctrlD.rs1       = instr[19:15];
        ctrlD.rs2       = instr[24:20];
        ctrlD.resultSrc = RES_ALU;
        ctrlD.pcSrc     = PC_PLUS4;
        ctrlD.immFmt    = IMM_I;
        ctrlD.aluOp     = ALU_ADD;
        ctrlD.memSize   = MEM_WORD;

        case (opcode)
            OPC_LOAD: begin
                ctrlD.aluSrc    = 1'b1;     // base + offset
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = RES_MEM;
                ctrlD.memSize   = memSize_e'(funct3);
                ctrlD.illegal   = (funct3 == 3'b011) || funct3[2:1] == 2'b11;
            end
            OPC_STORE: begin
                ctrlD.aluSrc   = 1'b1;
                ctrlD.memWrite = 1'b1;
                ctrlD.immFmt   = IMM_S;
                ctrlD.memSize  = memSize_e'(funct3);
                ctrlD.illegal  = funct3[2] || funct3 == 3'b011; // sb/sh/sw only
            end
            OPC_OP: begin
                ctrlD.regWrite = 1'b1;     // register operand b
                ctrlD.aluOp    = aluFromFunct3(funct3, funct7[5]);
                // only add/sub and srl/sra have an alternate funct7
                if (funct7 == 7'b0100000) begin
                    ctrlD.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                end else begin
                    ctrlD.illegal = (funct7 != 7'b0000000);
                end
            end
            OPC_OP_IMM: begin
                ctrlD.aluSrc   = 1'b1;
                ctrlD.regWrite = 1'b1;
                // no subi, funct7 only matters for srai
                ctrlD.aluOp    = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    ctrlD.illegal = (funct7 != 7'b0000000);   // slli
                end else if (funct3 == 3'b101) begin
                    ctrlD.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OPC_BRANCH: begin
                ctrlD.branch = 1'b1;
                ctrlD.immFmt = IMM_B;
                ctrlD.pcSrc  = PC_PLUS_IMM;
                case (funct3[2:1])
                    2'b00:   ctrlD.aluOp = ALU_SUB;   // beq/bne
                    2'b10:   ctrlD.aluOp = ALU_SLT;   // blt/bge
                    2'b11:   ctrlD.aluOp = ALU_SLTU;  // bltu/bgeu
                    default: ctrlD.illegal = 1'b1;
                endcase
            end
            OPC_AUIPC: begin
                ctrlD.aluSrc   = 1'b1;
                ctrlD.regWrite = 1'b1;
                ctrlD.usesPc   = 1'b1;  // pc + upper imm
                ctrlD.immFmt   = IMM_U;
            end
            OPC_LUI: begin
                ctrlD.aluSrc   = 1'b1;
                ctrlD.regWrite = 1'b1;
                ctrlD.immFmt   = IMM_U;
                ctrlD.aluOp    = ALU_PASS_B;
            end
            OPC_JAL: begin
                ctrlD.aluSrc    = 1'b1;
                ctrlD.regWrite  = 1'b1;     // link
                ctrlD.jump      = 1'b1;
                ctrlD.usesPc    = 1'b1;
                ctrlD.immFmt    = IMM_J;
                ctrlD.pcSrc     = PC_PLUS_IMM;
                ctrlD.resultSrc = RES_PC4;
            end
            OPC_JALR: begin
                // target is rs1 + imm, so operand a stays rs1
                ctrlD.aluSrc    = 1'b1;
                ctrlD.regWrite  = 1'b1;
                ctrlD.jump      = 1'b1;
                ctrlD.pcSrc     = PC_ALU_RESULT;
                ctrlD.resultSrc = RES_PC4;
                ctrlD.illegal   = (funct3 != 3'b000);
            end
            default: begin
                ctrlD.illegal = 1'b1;   // csr, fence, ecall land here too
            end
        endcase

        // sign-extended immediate per format
        case (ctrlD.immFmt)
            IMM_S:   ctrlD.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   ctrlD.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            IMM_U:   ctrlD.imm = {instr[31:12], 12'b0};
            IMM_J:   ctrlD.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            default: ctrlD.imm = {{20{instr[31]}}, instr[31:20]};
        endcase

        // an illegal word must not touch architectural state
        if (ctrlD.illegal) begin
            ctrlD.regWrite = 1'b0;
            ctrlD.memWrite = 1'b0;
            ctrlD.branch   = 1'b0;
            ctrlD.jump     = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // payload only moves on the strobe
    always_ff @(posedge clk) begin
        if (inValid) begin
            laneCtrl <= ctrlD;
        end
    end

endmodule

/* bundleCollector.sv */
`timescale 1ns/1ps
`include "rvDecode_defines.svh"

module bundleCollector import rvDecodePkg::*; (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,     // from lane 0
    input  laneCtrl_t [`RV_LANES-1:0]   laneCtrl,
    output logic                        decodeValid,
    output decodeBundle_t               decodeBundle
);

    decodeBundle_t bundleD;

    // lowest jump or illegal lane wins, everything above it is dropped
    always_comb begin
        logic cut;       // set once a redirecting lane is seen
        cut                = 1'b0;
        bundleD            = '0;
        bundleD.lane       = laneCtrl;
        for (int i = 0; i < `RV_LANES; i++) begin
            if (cut) begin
                bundleD.lane[i].valid    = 1'b0;
                bundleD.lane[i].regWrite = 1'b0;
                bundleD.lane[i].memWrite = 1'b0;
                bundleD.lane[i].branch   = 1'b0;
                bundleD.lane[i].jump     = 1'b0;
                bundleD.squashMask[i]    = 1'b1;
            end else begin
                bundleD.illegalAny = bundleD.illegalAny | laneCtrl[i].illegal;
                cut = laneCtrl[i].jump | laneCtrl[i].illegal;
            end
        end
    end

    // bundle cleared on reset so no valid bit leaks out
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decodeValid  <= 1'b0;
            decodeBundle <= '0;
        end else begin
            decodeValid <= inValid;
            if (inValid) begin
                decodeBundle <= bundleD;
            end
        end
    end

endmodule

/* rvDecodeUnit.sv */
`timescale 1ns/1ps
`include "rvDecode_defines.svh"

module rvDecodeUnit import rvDecodePkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          fetchValid,    // one-cycle strobe, no ready
    input  fetchPacket_t  fetchPacket,
    output logic          decodeValid,   // fetchValid + 3 cycles
    output decodeBundle_t decodeBundle
);

    logic                        laneValid;
    laneIn_t   [`RV_LANES-1:0]   laneIn;
    logic      [`RV_LANES-1:0]   laneOutValid;  // identical, lanes run in lockstep
    laneCtrl_t [`RV_LANES-1:0]   laneCtrl;
    logic                        ctrlValid;

    laneSplitter i_laneSplitter (
        .clk         (clk),
        .rstN        (rstN),
        .fetchValid  (fetchValid),
        .fetchPacket (fetchPacket),
        .laneValid   (laneValid),
        .laneIn      (laneIn)
    );

    for (genvar i = 0; i < `RV_LANES; i++) begin : gLane
        decodeLane i_decodeLane (
            .clk      (clk),
            .rstN     (rstN),
            .inValid  (laneValid),
            .laneIn   (laneIn[i]),
            .outValid (laneOutValid[i]),
            .laneCtrl (laneCtrl[i])
        );
    end

    assign ctrlValid = laneOutValid[0];  // lane 0 speaks for all

    bundleCollector i_bundleCollector (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (ctrlValid),
        .laneCtrl     (laneCtrl),
        .decodeValid  (decodeValid),
        .decodeBundle (decodeBundle)
    );

endmodule

/* rvDecodeUnit_asserts.sv */
`timescale 1ns/1ps
`include "rvDecode_defines.svh"

module rvDecodeUnit_asserts import rvDecodePkg::*; (
    input logic          clk,
    input logic          rstN,
    input logic          fetchValid,
    input logic          decodeValid,
    input decodeBundle_t decodeBundle
);

    // each strobe reappears exactly the pipeline depth later
    aStrobeOut: assert property (@(posedge clk) disable iff (!rstN)
        fetchValid |-> ##(`RV_DEC_LATENCY) decodeValid)
        else $error("decodeValid missing after fetchValid");

    // and nothing comes out that was not strobed in
    aNoStrayOut: assert property (@(posedge clk) disable iff (!rstN)
        decodeValid |-> $past(fetchValid, `RV_DEC_LATENCY))
        else $error("decodeValid without a matching fetchValid");

    aKnownValid: assert property (@(posedge clk) rstN |-> !$isunknown(decodeValid))
        else $error("decodeValid unknown after reset");

    // a squashed lane may never write state
    for (genvar i = 0; i < `RV_LANES; i++) begin : gSquash
        aSquashSafe: assert property (@(posedge clk) disable iff (!rstN)
            decodeValid && decodeBundle.squashMask[i] |->
                !decodeBundle.lane[i].regWrite && !decodeBundle.lane[i].memWrite)
            else $error("squashed lane %0d has a write enable set", i);
    end

endmodule

bind rvDecodeUnit rvDecodeUnit_asserts i_rvDecodeUnit_asserts (
    .clk          (clk),
    .rstN         (rstN),
    .fetchValid   (fetchValid),
    .decodeValid  (decodeValid),
    .decodeBundle (decodeBundle)
);

/* tb_rvDecodeUnit.sv */
`timescale 1ns/1ps
`include "rvDecode_defines.svh"

module tb_rvDecodeUnit import rvDecodePkg::*; ();

    localparam int DrainLimit = 50;   // cycles to wait for outstanding results
    localparam aluOp_e aluByF3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                       ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam opcode_e opList [9] = '{OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_BRANCH,
                                       OPC_AUIPC, OPC_LUI, OPC_JAL, OPC_JALR};
    localparam opcode_e fmtOps [6] = '{OPC_OP_IMM, OPC_STORE, OPC_BRANCH,
                                       OPC_LUI, OPC_AUIPC, OPC_JAL};
    localparam logic [31:0] Nop = 32'h0000_0013;  // addi x0, x0, 0

    logic          clk;
    logic          rstN;
    logic          fetchValid;
    fetchPacket_t  fetchPacket;
    logic          decodeValid;
    decodeBundle_t decodeBundle;

    decodeBundle_t expQ [$];        // expected bundles, oldest first
    decodeBundle_t expB;
    logic [`RV_DEC_LATENCY-1:0] vHist;  // fetchValid seen at the last few negedges
    int errors, checks, sent;
    int errAtStart, chkAtStart;
    logic timedOut;

    rvDecodeUnit i_rvDecodeUnit (
        .clk          (clk),
        .rstN         (rstN),
        .fetchValid   (fetchValid),
        .fetchPacket  (fetchPacket),
        .decodeValid  (decodeValid),
        .decodeBundle (decodeBundle)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected decode of one word, straight from the control table
    function automatic laneCtrl_t laneRef(input logic [31:0] w, input logic [`RV_XLEN-1:0] pc);
        laneCtrl_t c;
        logic [2:0] f3;
        logic [6:0] f7;
        logic signed [11:0] imm12;
        logic signed [12:0] imm13;
        logic signed [20:0] imm21;
        f3          = w[14:12];
        f7          = w[31:25];
        c           = '0;
        c.valid     = 1'b1;
        c.pc        = pc;
        c.rd        = w[11:7];
        c.rs1       = w[19:15];
        c.rs2       = w[24:20];
        c.resultSrc = RES_ALU;
        c.pcSrc     = PC_PLUS4;
        c.immFmt    = IMM_I;
        c.aluOp     = ALU_ADD;
        c.memSize   = MEM_WORD;
        case (w[6:0])
            OPC_LOAD: begin
                c.aluSrc    = 1'b1;
                c.regWrite  = 1'b1;
                c.resultSrc = RES_MEM;
                c.memSize   = memSize_e'(f3);
                c.illegal   = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            OPC_STORE: begin
                c.aluSrc   = 1'b1;
                c.memWrite = 1'b1;
                c.immFmt   = IMM_S;
                c.memSize  = memSize_e'(f3);
                c.illegal  = (f3 > 3'd2);   // sb, sh, sw
            end
            OPC_OP: begin
                c.regWrite = 1'b1;
                c.aluOp    = aluByF3[f3];
                if (f7[5] && f3 == 3'd0) c.aluOp = ALU_SUB;
                if (f7[5] && f3 == 3'd5) c.aluOp = ALU_SRA;
                c.illegal  = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            end
            OPC_OP_IMM: begin
                c.aluSrc   = 1'b1;
                c.regWrite = 1'b1;
                c.aluOp    = aluByF3[f3];   // no subi
                if (f7[5] && f3 == 3'd5) c.aluOp = ALU_SRA;
                c.illegal  = (f3 == 3'd1 && f7 != 7'h00) ||
                             (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            end
            OPC_BRANCH: begin
                c.branch = 1'b1;
                c.immFmt = IMM_B;
                c.pcSrc  = PC_PLUS_IMM;
                if (f3 == 3'd0 || f3 == 3'd1) c.aluOp = ALU_SUB;
                else if (f3 == 3'd4 || f3 == 3'd5) c.aluOp = ALU_SLT;
                else if (f3 == 3'd6 || f3 == 3'd7) c.aluOp = ALU_SLTU;
                else c.illegal = 1'b1;
            end
            OPC_AUIPC: begin
                c.aluSrc   = 1'b1;
                c.regWrite = 1'b1;
                c.usesPc   = 1'b1;
                c.immFmt   = IMM_U;
            end
            OPC_LUI: begin
                c.aluSrc   = 1'b1;
                c.regWrite = 1'b1;
                c.immFmt   = IMM_U;
                c.aluOp    = ALU_PASS_B;
            end
            OPC_JAL: begin
                c.aluSrc    = 1'b1;
                c.regWrite  = 1'b1;
                c.jump      = 1'b1;
                c.usesPc    = 1'b1;
                c.immFmt    = IMM_J;
                c.pcSrc     = PC_PLUS_IMM;
                c.resultSrc = RES_PC4;
            end
            OPC_JALR: begin
                c.aluSrc    = 1'b1;
                c.regWrite  = 1'b1;
                c.jump      = 1'b1;
                c.pcSrc     = PC_ALU_RESULT;
                c.resultSrc = RES_PC4;
                c.illegal   = (f3 != 3'd0);
            end
            default: c.illegal = 1'b1;
        endcase
        // reassemble the scattered immediate bits, then sign-extend
        case (c.immFmt)
            IMM_S: begin
                imm12 = {w[31:25], w[11:7]};
                c.imm = `RV_XLEN'(imm12);
            end
            IMM_B: begin
                imm13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
                c.imm = `RV_XLEN'(imm13);
            end
            IMM_U:   c.imm = {w[31:12], 12'h000};
            IMM_J: begin
                imm21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
                c.imm = `RV_XLEN'(imm21);
            end
            default: begin
                imm12 = w[31:20];
                c.imm = `RV_XLEN'(imm12);
            end
        endcase
        if (c.illegal) begin
            c.regWrite = 1'b0;
            c.memWrite = 1'b0;
            c.branch   = 1'b0;
            c.jump     = 1'b0;
        end
        return c;
    endfunction

    // whole packet: decode each lane, then cut everything after the first redirect
    function automatic decodeBundle_t bundleRef(input fetchPacket_t p);
        decodeBundle_t b;
        int cutAt;
        b     = '0;
        cutAt = `RV_LANES;
        for (int i = 0; i < `RV_LANES; i++) begin
            b.lane[i] = laneRef(p.instr[i], p.pc + `RV_XLEN'(4 * i));
            if (cutAt == `RV_LANES && (b.lane[i].jump || b.lane[i].illegal)) cutAt = i;
        end
        for (int i = 0; i < `RV_LANES; i++) begin
            if (i > cutAt) begin
                b.lane[i].valid    = 1'b0;
                b.lane[i].regWrite = 1'b0;
                b.lane[i].memWrite = 1'b0;
                b.lane[i].branch   = 1'b0;
                b.lane[i].jump     = 1'b0;
                b.squashMask[i]    = 1'b1;
            end else begin
                b.illegalAny = b.illegalAny | b.lane[i].illegal;
            end
        end
        return b;
    endfunction

    function automatic logic [31:0] randWord(input opcode_e op);
        logic [31:0] w;
        w      = $urandom();
        w[6:0] = op;
        return w;
    endfunction

    // force funct fields to the plain legal form of the opcode
    function automatic logic [31:0] fixFunct(input logic [31:0] w);
        logic [31:0] r;
        r = w;
        case (w[6:0])
            OPC_LOAD, OPC_STORE:            r[14:12] = 3'd2;   // word access
            OPC_OP_IMM, OPC_BRANCH, OPC_JALR: r[14:12] = 3'd0;
            OPC_OP: begin
                r[14:12] = 3'd0;
                r[31:25] = 7'h00;
            end
            default: r = w;
        endcase
        return r;
    endfunction

    function automatic fetchPacket_t makePacket(input logic [31:0] w0, input logic [31:0] w1);
        fetchPacket_t p;
        p.pc       = `RV_XLEN'($urandom() & 32'hFFFF_FFFC);
        p.instr[0] = w0;
        for (int i = 1; i < `RV_LANES; i++) p.instr[i] = w1;
        return p;
    endfunction

    task automatic sendPacket(input fetchPacket_t pkt);
        @(posedge clk);
        fetchValid  <= 1'b1;
        fetchPacket <= pkt;
        expQ.push_back(bundleRef(pkt));
        sent++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            fetchValid <= 1'b0;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        idleCycles(1);
        while (expQ.size() != 0 && waited < DrainLimit) begin
            idleCycles(1);
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("timeout: %0d expected bundles never came out", expQ.size());
            timedOut = 1'b1;
            expQ.delete();
        end
    endtask

    task automatic startTest();
        errAtStart = errors;
        chkAtStart = checks;
    endtask

    task automatic endTest(input string name);
        waitDrain();
        $display("test %-11s %5d checks, %0d errors", name, checks - chkAtStart,
                 errors - errAtStart);
    endtask

    task automatic failNote(input string what);
        errors++;
        $display("[FAIL] at %0t: %s", $time, what);
    endtask

    task automatic checkLane(input int idx, input laneCtrl_t got, input laneCtrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t decodeBundle.lane[%0d] got %h exp %h", $time, idx, got, exp);
        end
    endtask

    task automatic checkBundle(input decodeBundle_t got, input decodeBundle_t exp);
        checks += 2;
        if (got.illegalAny !== exp.illegalAny) begin
            errors++;
            $display("[ERROR] %0t decodeBundle.illegalAny got %b exp %b", $time,
                     got.illegalAny, exp.illegalAny);
        end
        if (got.squashMask !== exp.squashMask) begin
            errors++;
            $display("[ERROR] %0t decodeBundle.squashMask got %b exp %b", $time,
                     got.squashMask, exp.squashMask);
        end
    endtask

    // outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        if (!rstN) begin
            vHist = '0;
            if (decodeValid !== 1'b0) failNote("decodeValid high while in reset");
        end else begin
            if ($isunknown(decodeValid)) begin
                failNote("decodeValid is unknown after reset");
            end else if (decodeValid) begin
                if (!vHist[`RV_DEC_LATENCY-1]) begin
                    failNote("decodeValid without a strobe 3 cycles earlier");
                end
                if (expQ.size() == 0) begin
                    failNote("decodeValid arrived but no bundle was expected");
                end else begin
                    expB = expQ.pop_front();
                    for (int i = 0; i < `RV_LANES; i++) begin
                        checkLane(i, decodeBundle.lane[i], expB.lane[i]);
                    end
                    checkBundle(decodeBundle, expB);
                end
            end else if (vHist[`RV_DEC_LATENCY-1]) begin
                failNote("no decodeValid 3 cycles after a strobe");
            end
            vHist = {vHist[`RV_DEC_LATENCY-2:0], fetchValid};
        end
    end

    initial begin
        logic [31:0] w0;
        logic [31:0] w1;
        errors      = 0;
        checks      = 0;
        sent        = 0;
        timedOut    = 1'b0;
        vHist       = '0;
        void'($urandom(57));
        rstN        = 1'b0;
        fetchValid  = 1'b0;
        fetchPacket = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        startTest();               // decodeValid must stay quiet until a strobe
        idleCycles(8);
        endTest("reset");

        startTest();
        foreach (opList[k]) sendPacket(makePacket(fixFunct(randWord(opList[k])), Nop));
        endTest("opcodes");

        startTest();
        repeat (60) begin
            w0 = fixFunct(randWord(fmtOps[$urandom_range(0, 5)]));
            w1 = fixFunct(randWord(fmtOps[$urandom_range(0, 5)]));
            sendPacket(makePacket(w0, w1));
        end
        endTest("immediates");

        startTest();
        foreach (opList[k]) begin
            if (k < 5) begin       // load, store, op, op-imm, branch
                for (int f3 = 0; f3 < 8; f3++) begin
                    for (int alt = 0; alt < 2; alt++) begin
                        w0          = randWord(opList[k]);
                        w0[14:12]   = 3'(f3);
                        w0[31:25]   = (alt != 0) ? 7'h20 : 7'h00;
                        sendPacket(makePacket(w0, Nop));
                    end
                end
            end
        end
        endTest("alu_mem");

        startTest();
        sendPacket(makePacket(randWord(OPC_JAL), fixFunct(randWord(OPC_OP))));
        sendPacket(makePacket(fixFunct(randWord(OPC_JALR)), fixFunct(randWord(OPC_STORE))));
        sendPacket(makePacket(32'hFFFF_FFFF, fixFunct(randWord(OPC_LOAD))));
        sendPacket(makePacket(32'h0000_000F, 32'hFFFF_FFFF));   // fence, then junk
        sendPacket(makePacket(randWord(OPC_JAL), 32'hFFFF_FFFF)); // junk hidden behind a jump
        w0        = randWord(OPC_JALR);
        w0[14:12] = 3'd1;                                        // bad jalr funct3
        sendPacket(makePacket(w0, fixFunct(randWord(OPC_OP))));
        sendPacket(makePacket(Nop, randWord(OPC_JAL)));          // last lane jump
        sendPacket(makePacket(Nop, 32'h0000_0073));              // ecall in last lane
        endTest("squash");

        startTest();
        for (int n = 0; n < 200; n++) begin
            w0 = ($urandom_range(0, 3) == 0) ? $urandom() : randWord(opList[$urandom_range(0, 8)]);
            w1 = ($urandom_range(0, 3) == 0) ? $urandom() : randWord(opList[$urandom_range(0, 8)]);
            sendPacket(makePacket(w0, w1));
            if (n >= 100) idleCycles($urandom_range(0, 3));  // second half with gaps
        end
        endTest("throughput");

        $display("done: %0d packets, %0d checks, %0d errors", sent, checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
rvDecodePkg.sv
laneSplitter.sv
decodeLane.sv
bundleCollector.sv
rvDecodeUnit.sv
rvDecodeUnit_asserts.sv
tb_rvDecodeUnit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_rvDecodeUnit
FLIST     := flist.f
OBJDIR    := obj_dir
FLAGS     := --timing --assert
LINTFLAGS := --lint-only

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) $(FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# result is taken from the simulator output, a missing pass line fails the target
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
